// ==== rtl/cpu_regs_pkg.sv ====
// shared types and constants for the register file; enum encodings are fixed by the microcode
package cpu_regs_pkg;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2
    } width_t;

    typedef enum logic [1:0] {
        EXT_NONE = 2'd0,   // shifted register as is
        EXT_SIGN = 2'd1,
        EXT_ZERO = 2'd2
    } ext_t;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_DST  = 3'd1,
        LD_SR   = 3'd2,
        LD_RFP  = 3'd3,
        LD_CR   = 3'd4
    } ld_sel_t;

    typedef enum logic [2:0] {
        CC_NONE  = 3'd0,
        CC_ADD   = 3'd1,
        CC_SUB   = 3'd2,
        CC_LOGIC = 3'd3,
        CC_CARRY = 3'd4
    } cc_sel_t;

    typedef enum logic [1:0] {
        RM_SRC = 2'd0,
        RM_SR  = 2'd1,
        RM_CR  = 2'd2,
        RM_IMM = 2'd3
    } rmux_sel_t;

    localparam int RC_PTR_BIT = 7;        // pointer select in a register code
    localparam int RC_REL_BIT = 6;        // bank taken from rfp
    localparam int ACC_COUNT  = 16;
    localparam int PTR_COUNT  = 4;
    localparam int REG_COUNT  = ACC_COUNT + PTR_COUNT;

    localparam logic [1:0]  XSP_INDEX = 2'd3;    // stack pointer
    localparam logic [31:0] XSP_RESET = 32'h100;

    localparam logic [3:0] SR_FIXED_HI  = 4'b1000;   // constant one, then zeros
    localparam logic [1:0] SR_FIXED_MID = 2'b10;

    localparam int CR_COUNT = 8;

    localparam logic [7:0] DMP_SR_HI = 8'd80;
    localparam logic [7:0] DMP_SR_LO = 8'd81;

endpackage

// ==== rtl/reg_bank.sv ====
// accumulators and pointers; dump addresses decode absolute banks, never rfp-relative
`timescale 1ns/10ps

module reg_bank import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [1:0]  rfp,
    input  logic [7:0]  src,
    input  logic [7:0]  dst,
    input  width_t      width,
    input  logic        we,
    input  logic [31:0] rslt,
    input  logic [7:0]  dmp_addr,
    input  logic [15:0] sr,
    output logic [31:0] rd_lane,
    output logic [7:0]  dmp_dout
);

    logic [31:0] regs [REG_COUNT];   // 0..15 accumulators, 16..19 pointers
    logic [4:0]  wr_idx;
    logic [4:0]  rd_idx;
    logic [4:0]  wr_sh;
    logic [31:0] wr_mask;
    logic [31:0] wr_data;
    logic [4:0]  dmp_idx;
    logic [31:0] dmp_word;

    // flat index of a register code
    function automatic logic [4:0] reg_index(input logic [7:0] code, input logic [1:0] bank_ptr);
        logic [1:0] bank;
        bank = code[RC_REL_BIT] ? bank_ptr : code[5:4];
        if (code[RC_PTR_BIT]) begin
            return 5'(ACC_COUNT) | {3'b000, code[3:2]};
        end
        return {1'b0, bank, code[3:2]};
    endfunction

    // bit offset of the addressed lane
    function automatic logic [4:0] lane_shift(input logic [7:0] code, input width_t w);
        case (w)
            W_BYTE:  return {code[1:0], 3'b000};
            W_WORD:  return {code[1], 4'b0000};
            default: return 5'd0;
        endcase
    endfunction

    assign wr_idx  = reg_index(dst, rfp);
    assign rd_idx  = reg_index(src, rfp);
    assign wr_sh   = lane_shift(dst, width);
    assign wr_data = rslt << wr_sh;

    always_comb begin
        case (width)
            W_BYTE:  wr_mask = 32'h0000_00ff << wr_sh;
            W_WORD:  wr_mask = 32'h0000_ffff << wr_sh;
            default: wr_mask = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[5'(ACC_COUNT) | {3'b000, XSP_INDEX}] <= XSP_RESET;
        end else if (cen && we) begin
            regs[wr_idx] <= (regs[wr_idx] & ~wr_mask) | (wr_data & wr_mask);   // lane merge
        end
    end

    assign rd_lane = regs[rd_idx] >> lane_shift(src, width);   // right aligned

    // dump map: 0..63 accs, 64..79 pointers
    assign dmp_idx  = (dmp_addr[7:6] != 2'b00) ? (5'(ACC_COUNT) | {3'b000, dmp_addr[3:2]})
                                               : {1'b0, dmp_addr[5:2]};
    assign dmp_word = regs[dmp_idx];

    always_comb begin
        if (dmp_addr == DMP_SR_HI) begin
            dmp_dout = sr[15:8];
        end else if (dmp_addr == DMP_SR_LO) begin
            dmp_dout = sr[7:0];
        end else begin
            dmp_dout = dmp_word[{dmp_addr[1:0], 3'b000} +: 8];
        end
    end

    a_wr_known: assert property (@(posedge clk) disable iff (rst)
        (we && cen) |-> !$isunknown({dst, rslt}));

endmodule

// ==== rtl/flag_unit.sv ====
// main/alternate flags, bank pointer and SR; LD_SR takes priority over any flag rule
`timescale 1ns/10ps

module flag_unit import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  cc_sel_t     cc_sel,
    input  logic        exff,
    input  logic        si,
    input  logic        zi,
    input  logic        hi,
    input  logic        vi,
    input  logic        ci,
    input  ld_sel_t     ld_sel,
    input  width_t      width,
    input  logic [31:0] rslt,
    output logic [7:0]  flags,
    output logic        no,
    output logic        zo,
    output logic        co,
    output logic [1:0]  rfp,
    output logic [15:0] sr
);

    logic [5:0] main_f;   // {s, z, h, v, n, c}
    logic [5:0] alt_f;
    logic [5:0] cur_f;
    logic [5:0] nxt_f;

    always_comb begin
        cur_f = exff ? alt_f : main_f;   // swap first
        nxt_f = cur_f;
        case (cc_sel)
            CC_ADD:   nxt_f = {si, zi, hi, vi, 1'b0, ci};
            CC_SUB:   nxt_f = {si, zi, hi, vi, 1'b1, ci};
            CC_LOGIC: nxt_f = {si, zi, 1'b1, vi, 1'b0, 1'b0};
            CC_CARRY: nxt_f[0] = ci;
            default:  ;
        endcase
        if (ld_sel == LD_SR) begin
            nxt_f = {rslt[7], rslt[6], rslt[4], rslt[2], rslt[1], rslt[0]};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            main_f <= '0;
            alt_f  <= '0;
            rfp    <= '0;
        end else if (cen) begin
            main_f <= nxt_f;
            if (exff) alt_f <= main_f;
            if (ld_sel == LD_SR && width == W_WORD) rfp <= rslt[9:8];
            else if (ld_sel == LD_RFP) rfp <= rslt[1:0];
        end
    end

    assign flags = {main_f[5], main_f[4], 1'b0, main_f[3], 1'b0, main_f[2:0]};
    assign no    = main_f[1];
    assign zo    = main_f[4];
    assign co    = main_f[0];
    assign sr    = {SR_FIXED_HI, SR_FIXED_MID, rfp, flags};

    a_sr_no_cc: assert property (@(posedge clk) disable iff (rst)
        (ld_sel == LD_SR) |-> (cc_sel == CC_NONE));

endmodule

// ==== rtl/operand_mux.sv ====
// operand source select and extension; long operands are passed through unextended
`timescale 1ns/10ps

module operand_mux import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  rmux_sel_t   rmux_sel,
    input  logic        opnd_ld,
    input  width_t      width,
    input  ext_t        ext,
    input  logic [7:0]  src,
    input  logic [31:0] rd_lane,
    input  logic [15:0] sr,
    input  logic [31:0] cr_rdata,
    input  logic [31:0] rslt,
    output logic [2:0]  cr_raddr,
    output logic [31:0] op0
);

    logic [31:0] rmux;
    logic [31:0] ext_val;

    assign cr_raddr = src[2:0];   // control register number

    always_comb begin
        case (rmux_sel)
            RM_SRC:  rmux = rd_lane;
            RM_SR:   rmux = {16'h0000, sr};
            RM_CR:   rmux = cr_rdata;
            default: rmux = rslt;     // immediate
        endcase
    end

    always_comb begin
        ext_val = rmux;
        if (width == W_BYTE) begin
            case (ext)
                EXT_SIGN: ext_val[31:8] = {24{rmux[7]}};
                EXT_ZERO: ext_val[31:8] = '0;
                default:  ;
            endcase
        end else if (width == W_WORD) begin
            case (ext)
                EXT_SIGN: ext_val[31:16] = {16{rmux[15]}};
                EXT_ZERO: ext_val[31:16] = '0;
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            op0 <= '0;
        end else if (cen && opnd_ld) begin
            op0 <= ext_val;
        end
    end

endmodule

// ==== rtl/ctrl_regs.sv ====
// control registers with APB slave; APB side ignores cen, internal write wins a collision
`timescale 1ns/10ps

module ctrl_regs import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  ld_sel_t     ld_sel,
    input  logic [7:0]  dst,
    input  logic [31:0] rslt,
    input  logic [2:0]  cr_raddr,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] cr_rdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [31:0] crs [CR_COUNT];
    logic        cr_we;
    logic [2:0]  cr_waddr;
    logic [31:0] cr_wdata;
    logic        int_wr;
    logic        apb_acc;
    logic        addr_err;
    logic        apb_wr;

    assign int_wr   = cr_we & cen;
    assign apb_acc  = psel & penable;               // access phase
    assign addr_err = paddr >= 8'(CR_COUNT * 4);
    assign pready   = ~(apb_acc & pwrite & int_wr); // one wait on collision
    assign pslverr  = apb_acc & addr_err & pready;
    assign apb_wr   = apb_acc & pwrite & pready & ~addr_err;

    assign prdata   = addr_err ? 32'h0 : crs[paddr[4:2]];
    assign cr_rdata = crs[cr_raddr];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cr_we <= 1'b0;
        end else if (cen) begin
            cr_we <= (ld_sel == LD_CR);
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ld_sel == LD_CR) begin
            cr_waddr <= dst[2:0];
            cr_wdata <= rslt;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CR_COUNT; i++) begin
                crs[i] <= '0;
            end
        end else begin
            if (int_wr) crs[cr_waddr] <= cr_wdata;
            if (apb_wr) crs[paddr[4:2]] <= pwdata;   // never together with int_wr
        end
    end

    a_pen_psel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

endmodule

// ==== rtl/regs_top.sv ====
// operand register file top; micro-op port has no back-pressure, one op per cen cycle
`timescale 1ns/10ps

module regs_top import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  src,
    input  logic [7:0]  dst,
    input  width_t      width,
    input  ext_t        ext,
    input  rmux_sel_t   rmux_sel,
    input  logic        opnd_ld,
    input  ld_sel_t     ld_sel,
    input  cc_sel_t     cc_sel,
    input  logic        exff,
    input  logic [31:0] rslt,
    input  logic        si,
    input  logic        zi,
    input  logic        hi,
    input  logic        vi,
    input  logic        ci,
    output logic [31:0] op0,
    output logic [7:0]  flags,
    output logic        no,
    output logic        zo,
    output logic        co,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [1:0]  rfp;
    logic [15:0] sr;
    logic [31:0] rd_lane;
    logic [2:0]  cr_raddr;
    logic [31:0] cr_rdata;
    logic        we;

    assign we = (ld_sel == LD_DST);   // register write decode

    reg_bank i_bank (
        .clk(clk), .rst(rst), .cen(cen), .rfp(rfp), .src(src), .dst(dst),
        .width(width), .we(we), .rslt(rslt), .dmp_addr(dmp_addr), .sr(sr),
        .rd_lane(rd_lane), .dmp_dout(dmp_dout)
    );

    flag_unit i_flags (
        .clk(clk), .rst(rst), .cen(cen), .cc_sel(cc_sel), .exff(exff),
        .si(si), .zi(zi), .hi(hi), .vi(vi), .ci(ci), .ld_sel(ld_sel),
        .width(width), .rslt(rslt), .flags(flags), .no(no), .zo(zo), .co(co),
        .rfp(rfp), .sr(sr)
    );

    operand_mux i_opnd (
        .clk(clk), .rst(rst), .cen(cen), .rmux_sel(rmux_sel), .opnd_ld(opnd_ld),
        .width(width), .ext(ext), .src(src), .rd_lane(rd_lane), .sr(sr),
        .cr_rdata(cr_rdata), .rslt(rslt), .cr_raddr(cr_raddr), .op0(op0)
    );

    ctrl_regs i_cr (
        .clk(clk), .rst(rst), .cen(cen), .ld_sel(ld_sel), .dst(dst), .rslt(rslt),
        .cr_raddr(cr_raddr), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .cr_rdata(cr_rdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr)
    );

endmodule

// ==== test/tb_regs_ref.svh ====
// shadow model of regs_top state; include inside a module that imports cpu_regs_pkg
`ifndef TB_REGS_REF_SVH
`define TB_REGS_REF_SVH

logic [31:0] m_regs [20];   // 0..15 accumulators, 16..19 pointers
logic [7:0]  m_main;        // kept in flags byte layout
logic [7:0]  m_alt;
logic [1:0]  m_rfp;
logic [31:0] m_cr [8];

function automatic void model_reset();
    foreach (m_regs[i]) m_regs[i] = 32'h0;
    foreach (m_cr[i]) m_cr[i] = 32'h0;
    m_regs[19] = 32'h100;   // stack pointer
    m_main = 8'h00;
    m_alt = 8'h00;
    m_rfp = 2'd0;
endfunction

// storage slot named by a register code
function automatic int reg_of(input logic [7:0] code);
    logic [1:0] bank;
    if (code[7]) begin
        return 16 + code[3:2];
    end
    bank = code[6] ? m_rfp : code[5:4];
    return bank * 4 + code[3:2];
endfunction

function automatic int lane_base(input logic [7:0] code, input width_t w);
    if (w == W_BYTE) return code[1:0];
    if (w == W_WORD) return code[1] * 2;
    return 0;
endfunction

function automatic void model_write(input logic [7:0] code, input width_t w,
                                    input logic [31:0] val);
    int idx;
    int base;
    int nbytes;
    idx = reg_of(code);
    base = lane_base(code, w);
    nbytes = (w == W_BYTE) ? 1 : (w == W_WORD) ? 2 : 4;
    for (int b = 0; b < nbytes; b++) begin
        m_regs[idx][(base + b) * 8 +: 8] = val[b * 8 +: 8];
    end
endfunction

// one clock-enabled edge of the micro-op port
function automatic void model_step(input logic [7:0] d, input width_t w, input ld_sel_t ld,
                                   input cc_sel_t cc, input logic x, input logic s,
                                   input logic z, input logic h, input logic v,
                                   input logic c, input logic [31:0] r);
    logic [7:0] f;
    if (ld == LD_DST) model_write(d, w, r);   // uses rfp before the edge
    if (ld == LD_CR) m_cr[d[2:0]] = r;
    f = x ? m_alt : m_main;
    if (x) m_alt = m_main;
    case (cc)
        CC_ADD:   f = {s, z, 1'b0, h, 1'b0, v, 1'b0, c};
        CC_SUB:   f = {s, z, 1'b0, h, 1'b0, v, 1'b1, c};
        CC_LOGIC: f = {s, z, 1'b0, 1'b1, 1'b0, v, 1'b0, 1'b0};
        CC_CARRY: f[0] = c;
        default:  ;
    endcase
    if (ld == LD_SR) f = r[7:0] & 8'hd7;   // unused bits read as zero
    m_main = f;
    if (ld == LD_SR && w == W_WORD) m_rfp = r[9:8];
    if (ld == LD_RFP) m_rfp = r[1:0];
endfunction

function automatic logic [7:0] ref_flags();
    return m_main;
endfunction

function automatic logic [15:0] ref_sr();
    return {1'b1, 3'b000, 2'b10, m_rfp, m_main};
endfunction

function automatic logic [7:0] ref_dump(input int a);
    logic [15:0] sr_val;
    int idx;
    sr_val = ref_sr();
    if (a == 80) return sr_val[15:8];
    if (a == 81) return sr_val[7:0];
    idx = (a < 64) ? a / 4 : 16 + (a - 64) / 4;
    return m_regs[idx][(a % 4) * 8 +: 8];
endfunction

function automatic logic [31:0] ref_operand(input rmux_sel_t sel, input width_t w,
                                            input ext_t e, input logic [7:0] s,
                                            input logic [31:0] r);
    logic [31:0] v;
    case (sel)
        RM_SRC:  v = m_regs[reg_of(s)] >> (lane_base(s, w) * 8);
        RM_SR:   v = {16'h0000, ref_sr()};
        RM_CR:   v = m_cr[s[2:0]];
        default: v = r;
    endcase
    if (w == W_BYTE && e == EXT_SIGN) v = {{24{v[7]}}, v[7:0]};
    if (w == W_BYTE && e == EXT_ZERO) v = {24'h0, v[7:0]};
    if (w == W_WORD && e == EXT_SIGN) v = {{16{v[15]}}, v[15:0]};
    if (w == W_WORD && e == EXT_ZERO) v = {16'h0, v[15:0]};
    return v;
endfunction

`endif

// ==== test/tb_regs.sv ====
// self-checking testbench for regs_top; stops at the first mismatch, cen stays high throughout
`timescale 1ns/10ps

module tb_regs import cpu_regs_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;   // about three times the test length

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  src;
    logic [7:0]  dst;
    width_t      width;
    ext_t        ext;
    rmux_sel_t   rmux_sel;
    logic        opnd_ld;
    ld_sel_t     ld_sel;
    cc_sel_t     cc_sel;
    logic        exff;
    logic [31:0] rslt;
    logic        si;
    logic        zi;
    logic        hi;
    logic        vi;
    logic        ci;
    logic [31:0] op0;
    logic [7:0]  flags;
    logic        no;
    logic        zo;
    logic        co;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    integer      seed;
    int          cycles = 0;
    logic [31:0] exp_op;
    logic [31:0] data_tmp;

    `include "tb_regs_ref.svh"

    regs_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    // no, zo and co follow bits 1, 6 and 0 of the flags byte
    task automatic check_flags(input string name, input logic [7:0] exp, input logic [7:0] act,
                               input logic act_n, input logic act_z, input logic act_c);
        if ({act, act_n, act_z, act_c} !== {exp, exp[1], exp[6], exp[0]}) begin
            $display("ERROR %s: expected %h, actual %h", name,
                     {exp, exp[1], exp[6], exp[0]}, {act, act_n, act_z, act_c});
            fail_run();
        end
    endtask

    task automatic check_resp(input string name, input logic exp_rdy, input logic exp_err,
                              input logic act_rdy, input logic act_err);
        if ({act_rdy, act_err} !== {exp_rdy, exp_err}) begin
            $display("ERROR %s: expected %b, actual %b", name,
                     {exp_rdy, exp_err}, {act_rdy, act_err});
            fail_run();
        end
    endtask

    // flags are compared every cycle, away from the edges
    always @(negedge clk) begin
        if (!rst) check_flags("flags", ref_flags(), flags, no, zo, co);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_op();
        @(posedge clk);
        model_step(dst, width, ld_sel, cc_sel, exff, si, zi, hi, vi, ci, rslt);
        #1;
        ld_sel = LD_NONE;
        cc_sel = CC_NONE;
        exff = 1'b0;
        opnd_ld = 1'b0;
    endtask

    task automatic dump_bytes(input string name, input int lo, input int n);
        for (int a = lo; a < lo + n; a++) begin
            dmp_addr = 8'(a);
            @(negedge clk);
            check_byte(name, ref_dump(a), dmp_dout);
            next_cycle();
        end
    endtask

    task automatic write_and_dump(input string name, input logic [7:0] code, input width_t w,
                                  input logic [31:0] val);
        int base;
        base = reg_of(code) * 4;   // byte 0 of the target, resolved before the edge
        dst = code;
        width = w;
        rslt = val;
        ld_sel = LD_DST;
        apply_op();
        dump_bytes(name, base, 4);
    endtask

    task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input int exp_waits);
        int n;
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            @(negedge clk);
        end
        check_resp(name, 1'b1, exp_err, pready, pslverr);
        check_word(name, exp_waits, n);
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        if (!exp_err) m_cr[addr[4:2]] = data;
    endtask

    task automatic apb_read(input string name, input logic [7:0] addr, input logic exp_err);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        check_resp(name, 1'b1, exp_err, pready, pslverr);
        if (!exp_err) check_word(name, m_cr[addr[4:2]], prdata);
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        seed = 86;
        rst = 1'b1;
        cen = 1'b1;
        src = 8'h00;
        dst = 8'h00;
        width = W_BYTE;
        ext = EXT_NONE;
        rmux_sel = RM_SRC;
        opnd_ld = 1'b0;
        ld_sel = LD_NONE;
        cc_sel = CC_NONE;
        exff = 1'b0;
        rslt = 32'h0;
        si = 1'b0;
        zi = 1'b0;
        hi = 1'b0;
        vi = 1'b0;
        ci = 1'b0;
        dmp_addr = 8'h00;
        paddr = 8'h00;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        model_reset();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        dump_bytes("reset dump", 0, 82);

        for (int i = 0; i < 40; i++) begin
            if ($random(seed) & 1) begin
                ld_sel = LD_RFP;   // new bank for relative codes
                rslt = $random(seed);
                apply_op();
            end
            write_and_dump("random write", 8'($random(seed)),
                           width_t'($unsigned($random(seed)) % 3), $random(seed));
        end
        dump_bytes("write sweep", 0, 82);

        for (int i = 0; i < 27; i++) begin
            width = width_t'(i % 3);
            ext = ext_t'((i / 3) % 3);
            rmux_sel = (i < 9) ? RM_SRC : (i < 18) ? RM_SR : RM_IMM;
            src = 8'($random(seed));
            rslt = $random(seed);
            opnd_ld = 1'b1;
            exp_op = ref_operand(rmux_sel, width, ext, src, rslt);
            apply_op();
            check_word("operand read", exp_op, op0);
        end

        for (int i = 0; i < 40; i++) begin
            exff = 1'($random(seed));
            if (i % 6 == 5) begin
                ld_sel = LD_SR;
                width = ($random(seed) & 1) ? W_WORD : W_BYTE;
                rslt = $random(seed);
            end else begin
                cc_sel = cc_sel_t'(i % 6);
                {si, zi, hi, vi, ci} = 5'($random(seed));
            end
            apply_op();
            check_flags("flag rule", ref_flags(), flags, no, zo, co);
            dump_bytes("sr dump", 80, 2);
        end

        for (int a = 0; a < 8; a++) begin
            apb_write("apb write", 8'(a * 4), $random(seed), 1'b0, 0);
        end
        for (int a = 0; a < 8; a++) begin
            apb_read("apb read", 8'(a * 4), 1'b0);
        end
        apb_write("apb bad write", 8'd32, $random(seed), 1'b1, 0);
        apb_write("apb bad write", 8'hfc, $random(seed), 1'b1, 0);
        apb_read("apb bad read", 8'd40, 1'b1);
        for (int a = 0; a < 8; a++) begin
            apb_read("apb read after error", 8'(a * 4), 1'b0);
        end

        dst = 8'd3;
        rslt = $random(seed);
        ld_sel = LD_CR;
        data_tmp = $random(seed);
        fork
            apply_op();
            apb_write("apb collision", 8'd20, data_tmp, 1'b0, 1);   // cr_we holds it off
        join
        apb_read("collision internal", 8'd12, 1'b0);
        apb_read("collision apb", 8'd20, 1'b0);

        dst = 8'd6;
        rslt = $random(seed);
        ld_sel = LD_CR;
        apply_op();
        next_cycle();   // internal write lands on this edge
        rmux_sel = RM_CR;
        src = 8'd6;
        width = W_LONG;
        ext = EXT_NONE;
        opnd_ld = 1'b1;
        exp_op = ref_operand(rmux_sel, width, ext, src, rslt);
        apply_op();
        check_word("cr operand", exp_op, op0);

        for (int r = 0; r < 4; r++) begin
            ld_sel = LD_RFP;
            rslt = 32'(r);
            apply_op();
            write_and_dump("rfp write", {4'b0100, 2'($random(seed)), 2'b00}, W_LONG,
                           $random(seed));
            ld_sel = LD_SR;
            width = W_WORD;
            rslt = {22'h0, 2'(3 - r), 8'($random(seed))};
            apply_op();
            dump_bytes("sr after word load", 80, 2);
            write_and_dump("sr bank write", {4'b0100, 2'($random(seed)), 2'b00}, W_LONG,
                           $random(seed));
        end
        dump_bytes("final sweep", 0, 82);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+test
rtl/cpu_regs_pkg.sv
rtl/reg_bank.sv
rtl/flag_unit.sv
rtl/operand_mux.sv
rtl/ctrl_regs.sv
rtl/regs_top.sv
test/tb_regs.sv
